//--- rtl/gcm_auth_top.sv
`timescale 1ns/1ns

module gcm_auth_top
    import gcm_pkg::*, gcm_ctrl_pkg::*;
#(
    parameter int CNT_W = 32
)
(
    input  logic         clk,
    input  logic         i_rst_n,
    input  logic         i_new_instance,
    input  gcm_block_t   i_h,
    input  gcm_in_t      i_item,
    output gcm_ct_out_t  o_ct,
    output gcm_tag_out_t o_tag
);

    gcm_stage_t w_stage;
    gcm_fin_t   w_fin;

    // counts, H and the length block
    gcm_ingress #(
        .CNT_W(CNT_W)
    ) u_ingress (
        .clk            (clk),
        .i_rst_n        (i_rst_n),
        .i_new_instance (i_new_instance),
        .i_h            (i_h),
        .i_item         (i_item),
        .o_stage        (w_stage)
    );

    ghash_accumulator u_accum (
        .clk     (clk),
        .i_rst_n (i_rst_n),
        .i_stage (w_stage),
        .o_fin   (w_fin)
    );

    // tag and reversed ciphertext
    gcm_tag_stage u_tag (
        .clk     (clk),
        .i_rst_n (i_rst_n),
        .i_fin   (w_fin),
        .o_ct    (o_ct),
        .o_tag   (o_tag)
    );

endmodule

//--- rtl/gcm_ctrl_pkg.sv
package gcm_ctrl_pkg;

    import gcm_pkg::*;

    typedef enum logic [1:0] {
        AAD   = 2'd0,
        TEXT  = 2'd1,
        FINAL = 2'd2
    } gcm_kind_e;

    // host item, block holds E(K,J0) when kind is FINAL
    typedef struct packed {
        logic       valid;
        gcm_kind_e  kind;
        gcm_block_t block;
    } gcm_in_t;

    // ingress to accumulator
    typedef struct packed {
        logic           valid;
        gcm_kind_e      kind;
        gcm_block_t     block;
        gcm_block_t     h;
        gcm_len_block_u len;
    } gcm_stage_t;

    // accumulator to tag stage
    typedef struct packed {
        logic           ct_valid;
        gcm_block_t     ct;
        logic           tag_valid;
        gcm_block_t     ghash;
        gcm_len_block_u len;
        gcm_block_t     ekj0;
        gcm_block_t     h;
    } gcm_fin_t;

    typedef struct packed {
        logic       valid;
        gcm_block_t block;
    } gcm_ct_out_t;

    typedef struct packed {
        logic       valid;
        gcm_block_t tag;
    } gcm_tag_out_t;

endpackage

//--- rtl/gcm_ingress.sv
`timescale 1ns/1ns

module gcm_ingress
    import gcm_pkg::*, gcm_ctrl_pkg::*;
#(
    parameter int CNT_W = 32
)
(
    input  logic       clk,
    input  logic       i_rst_n,
    input  logic       i_new_instance,
    input  gcm_block_t i_h,
    input  gcm_in_t    i_item,
    output gcm_stage_t o_stage
);

    logic [CNT_W-1:0] r_aad_cnt;
    logic [CNT_W-1:0] r_text_cnt;
    logic             r_valid;
    gcm_kind_e        r_kind;
    gcm_block_t       r_h;
    gcm_block_t       r_block;
    gcm_block_t       r_item_h;
    gcm_len_block_u   r_len;
    gcm_len_block_u   w_len;
    logic             w_is_aad;
    logic             w_is_text;
    logic             w_is_final;

    assign w_is_aad   = i_item.valid && (i_item.kind == AAD);
    assign w_is_text  = i_item.valid && (i_item.kind == TEXT);
    assign w_is_final = i_item.valid && (i_item.kind == FINAL);

    // counts to bit lengths, every block is 128 bits
    always_comb
    begin
        w_len.lens.aad_bits = 64'(r_aad_cnt) << 7;
        w_len.lens.ct_bits  = 64'(r_text_cnt) << 7;
    end

    always_ff @(posedge clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            r_valid    <= 1'b0;
            r_kind     <= AAD;
            r_aad_cnt  <= '0;
            r_text_cnt <= '0;
        end
        else
        begin
            r_valid <= i_item.valid;
            r_kind  <= i_item.kind;
            // final takes the counts as they stand, then starts over
            if (i_new_instance || w_is_final)
            begin
                r_aad_cnt  <= '0;
                r_text_cnt <= '0;
            end
            else
            begin
                if (w_is_aad)
                begin
                    r_aad_cnt <= r_aad_cnt + 1'b1;
                end
                if (w_is_text)
                begin
                    r_text_cnt <= r_text_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (i_new_instance)
        begin
            r_h <= i_h;
        end
        r_block  <= i_item.block;
        r_item_h <= r_h;
        r_len    <= w_len;
    end

    always_comb
    begin
        o_stage.valid = r_valid;
        o_stage.kind  = r_kind;
        o_stage.block = r_block;
        o_stage.h     = r_item_h;
        o_stage.len   = r_len;
    end

endmodule

//--- rtl/gcm_pkg.sv
package gcm_pkg;

    // bit 0 is the leftmost bit of a block, as GCM numbers it
    typedef logic [0:127] gcm_block_t;

    // bit lengths of the two inputs, aad first
    typedef struct packed {
        logic [0:63] aad_bits;
        logic [0:63] ct_bits;
    } gcm_len_fields_t;

    // the len(A) || len(C) block
    // written as two lengths, hashed as a plain block
    typedef union packed {
        gcm_len_fields_t lens;
        gcm_block_t      raw;
    } gcm_len_block_u;

    // reduction constant R = 11100001 || 0^120
    localparam gcm_block_t GCM_R = {8'he1, 120'd0};

    // GF(2^128) product in GCM bit order
    // shift-and-add over the bits of x, reducing v on every step
    function automatic gcm_block_t gf128_mul(input gcm_block_t x, input gcm_block_t y);
        gcm_block_t z;
        gcm_block_t v;
        z = '0;
        v = y;
        for (int i = 0; i < 128; i++)
        begin
            if (x[i])
            begin
                z = z ^ v;
            end
            // a right shift in this bit order moves toward x^127
            if (v[127])
            begin
                v = (v >> 1) ^ GCM_R;
            end
            else
            begin
                v = v >> 1;
            end
        end
        return z;
    endfunction

endpackage

//--- rtl/gcm_tag_stage.sv
`timescale 1ns/1ns

module gcm_tag_stage
    import gcm_pkg::*, gcm_ctrl_pkg::*;
(
    input  logic         clk,
    input  logic         i_rst_n,
    input  gcm_fin_t     i_fin,
    output gcm_ct_out_t  o_ct,
    output gcm_tag_out_t o_tag
);

    logic           r_ct_valid;
    logic           r_tag_valid;
    gcm_block_t     r_ct;
    gcm_block_t     r_ghash;
    gcm_len_block_u r_len;
    gcm_block_t     r_ekj0;
    gcm_block_t     r_h;
    gcm_block_t     w_ct_rev;
    gcm_block_t     w_s;

    always_ff @(posedge clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            r_ct_valid  <= 1'b0;
            r_tag_valid <= 1'b0;
        end
        else
        begin
            r_ct_valid  <= i_fin.ct_valid;
            r_tag_valid <= i_fin.tag_valid;
        end
    end

    always_ff @(posedge clk)
    begin
        r_ct    <= i_fin.ct;
        r_ghash <= i_fin.ghash;
        r_len   <= i_fin.len;
        r_ekj0  <= i_fin.ekj0;
        r_h     <= i_fin.h;
    end

    // byte 0 of the output is byte 15 of the block
    always_comb
    begin
        for (int n = 0; n < 16; n++)
        begin
            w_ct_rev[n*8 +: 8] = r_ct[(15-n)*8 +: 8];
        end
    end

    // last GHASH step folds in the length block
    assign w_s = gf128_mul(r_ghash ^ r_len.raw, r_h);

    always_comb
    begin
        o_ct.valid  = r_ct_valid;
        o_ct.block  = w_ct_rev;
        o_tag.valid = r_tag_valid;
        o_tag.tag   = w_s ^ r_ekj0;
    end

endmodule

//--- rtl/ghash_accumulator.sv
`timescale 1ns/1ns

module ghash_accumulator
    import gcm_pkg::*, gcm_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       i_rst_n,
    input  gcm_stage_t i_stage,
    output gcm_fin_t   o_fin
);

    gcm_block_t     r_state;
    logic           r_ct_valid;
    logic           r_tag_valid;
    gcm_block_t     r_ct;
    gcm_block_t     r_ghash;
    gcm_len_block_u r_len;
    gcm_block_t     r_ekj0;
    gcm_block_t     r_h;
    logic           w_is_data;
    logic           w_is_text;
    logic           w_is_final;
    gcm_block_t     w_next;

    assign w_is_data  = i_stage.valid && (i_stage.kind != FINAL);
    assign w_is_text  = i_stage.valid && (i_stage.kind == TEXT);
    assign w_is_final = i_stage.valid && (i_stage.kind == FINAL);

    // one GHASH step: (Y xor X) * H
    assign w_next = gf128_mul(r_state ^ i_stage.block, i_stage.h);

    always_ff @(posedge clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            r_state     <= '0;
            r_ct_valid  <= 1'b0;
            r_tag_valid <= 1'b0;
        end
        else
        begin
            r_ct_valid  <= w_is_text;
            r_tag_valid <= w_is_final;
            if (w_is_final)
            begin
                // next instance starts from zero
                r_state <= '0;
            end
            else if (w_is_data)
            begin
                r_state <= w_next;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (w_is_text)
        begin
            r_ct <= i_stage.block;
        end
        if (w_is_final)
        begin
            r_ghash <= r_state;
            r_len   <= i_stage.len;
            r_ekj0  <= i_stage.block;
            r_h     <= i_stage.h;
        end
    end

    always_comb
    begin
        o_fin.ct_valid  = r_ct_valid;
        o_fin.ct        = r_ct;
        o_fin.tag_valid = r_tag_valid;
        o_fin.ghash     = r_ghash;
        o_fin.len       = r_len;
        o_fin.ekj0      = r_ekj0;
        o_fin.h         = r_h;
    end

endmodule

//--- src.f
rtl/gcm_pkg.sv
rtl/gcm_ctrl_pkg.sv
rtl/gcm_ingress.sv
rtl/ghash_accumulator.sv
rtl/gcm_tag_stage.sv
rtl/gcm_auth_top.sv
test/tb_clock_gen.sv
test/tb_gcm_auth.sv

//--- test/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int HALF_PERIOD = 2,
    parameter int RST_CYCLES  = 10
)
(
    output logic clk,
    output logic o_rst_n
);

    initial
    begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // reset released on a rising edge, like the rest of the stimulus
    initial
    begin
        o_rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        o_rst_n <= 1'b1;
    end

endmodule

//--- test/tb_gcm_auth.sv
`timescale 1ns/1ns

module tb_gcm_auth
    import gcm_pkg::*, gcm_ctrl_pkg::*;
;

    typedef struct packed {
        logic [31:0]  due;
        logic [127:0] value;
    } expect_t;

    logic         clk;
    logic         rst_n;
    logic         i_new_instance;
    gcm_block_t   i_h;
    gcm_in_t      i_item;
    gcm_ct_out_t  o_ct;
    gcm_tag_out_t o_tag;

    logic [31:0]  cyc;
    logic [31:0]  since_rst;
    logic [31:0]  limit;
    logic [31:0]  lcg_state;
    expect_t      ct_q[$];
    expect_t      tag_q[$];
    expect_t      ct_head;
    expect_t      tag_head;
    logic         ct_head_valid;
    logic         tag_head_valid;
    logic         in_reset_window;
    gcm_kind_e    seq_kind[$];
    logic [127:0] seq_blk[$];
    int           rnd_aad[8];
    int           rnd_text[8];

    tb_clock_gen u_clk (
        .clk     (clk),
        .o_rst_n (rst_n)
    );

    gcm_auth_top #(
        .CNT_W(32)
    ) u_dut (
        .clk            (clk),
        .i_rst_n        (rst_n),
        .i_new_instance (i_new_instance),
        .i_h            (i_h),
        .i_item         (i_item),
        .o_ct           (o_ct),
        .o_tag          (o_tag)
    );

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [127:0] rand_block();
        logic [127:0] b;
        for (int k = 0; k < 4; k++)
        begin
            b[32*k +: 32] = lcg_next();
        end
        return b;
    endfunction

    // multiply by alpha as one reduced shift toward x^127
    function automatic logic [127:0] mul_alpha(input logic [127:0] v);
        if (v[0])
        begin
            return (v >> 1) ^ {8'he1, 120'd0};
        end
        return v >> 1;
    endfunction

    // horner over the coefficients of x from the highest degree down
    // coefficient i of x sits at vector bit 127-i
    function automatic logic [127:0] ref_gf_mul(input logic [127:0] x, input logic [127:0] y);
        logic [127:0] z;
        z = '0;
        for (int i = 127; i >= 0; i--)
        begin
            z = mul_alpha(z);
            if (x[127 - i])
            begin
                z = z ^ y;
            end
        end
        return z;
    endfunction

    function automatic logic [127:0] byte_swap(input logic [127:0] b);
        logic [127:0] r;
        for (int k = 0; k < 16; k++)
        begin
            r[8*k +: 8] = b[127 - 8*k -: 8];
        end
        return r;
    endfunction

    // GHASH over the current item sequence and then the length block
    function automatic logic [127:0] model_tag(input logic [127:0] h, input logic [127:0] ekj0);
        logic [127:0] y;
        logic [63:0]  a_bits;
        logic [63:0]  c_bits;
        y = '0;
        a_bits = '0;
        c_bits = '0;
        foreach (seq_blk[k])
        begin
            y = ref_gf_mul(y ^ seq_blk[k], h);
            if (seq_kind[k] == AAD)
            begin
                a_bits = a_bits + 64'd128;
            end
            else
            begin
                c_bits = c_bits + 64'd128;
            end
        end
        return ref_gf_mul(y ^ {a_bits, c_bits}, h) ^ ekj0;
    endfunction

    task automatic report_failure(input string what);
        $display("%0t: %s", $time, what);
        $display("CHECKS FAILED");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic report_mismatch(input string name, input logic [127:0] expected,
                                   input logic [127:0] actual);
        $display("ERR t=%0t %s expected %h got %h", $time, name, expected, actual);
        $display("CHECKS FAILED");
        $fatal(1, "stopped at first mismatch");
    endtask

    // random mix of aad and text blocks in random order
    task automatic fill_seq(input int n_aad, input int n_text);
        logic [31:0] r;
        seq_kind.delete();
        seq_blk.delete();
        while (n_aad + n_text > 0)
        begin
            r = lcg_next();
            if (n_aad > 0 && (n_text == 0 || r[16]))
            begin
                seq_kind.push_back(AAD);
                n_aad--;
            end
            else
            begin
                seq_kind.push_back(TEXT);
                n_text--;
            end
            seq_blk.push_back(rand_block());
        end
    endtask

    task automatic drive_new(input logic [127:0] h);
        @(posedge clk);
        i_new_instance <= 1'b1;
        i_h            <= h;
        i_item.valid   <= 1'b0;
    endtask

    task automatic drive_idle();
        @(posedge clk);
        i_new_instance <= 1'b0;
        i_item.valid   <= 1'b0;
    endtask

    task automatic drive_item(input gcm_kind_e item_kind, input logic [127:0] blk,
                              input logic [127:0] expected);
        expect_t e;
        @(posedge clk);
        i_new_instance <= 1'b0;
        i_item         <= '{valid: 1'b1, kind: item_kind, block: blk};
        // sampled on the next edge and seen at the output three edges later
        e.due   = cyc + 32'd4;
        e.value = expected;
        if (item_kind == TEXT)
        begin
            ct_q.push_back(e);
        end
        else if (item_kind == FINAL)
        begin
            tag_q.push_back(e);
        end
    endtask

    task automatic run_instance(input logic [127:0] h, input logic [127:0] ekj0);
        logic [127:0] tag;
        tag = model_tag(h, ekj0);
        drive_new(h);
        foreach (seq_blk[k])
        begin
            drive_item(seq_kind[k], seq_blk[k], byte_swap(seq_blk[k]));
        end
        drive_item(FINAL, ekj0, tag);
    endtask

    assign in_reset_window = (cyc >= 32'd1) && (since_rst < 32'd3);

    // scoreboard heads, cycle count and watchdog
    always @(posedge clk)
    begin
        cyc <= cyc + 32'd1;
        if (rst_n)
        begin
            since_rst <= since_rst + 32'd1;
        end
        if (o_ct.valid && ct_q.size() != 0)
        begin
            void'(ct_q.pop_front());
        end
        if (o_tag.valid && tag_q.size() != 0)
        begin
            void'(tag_q.pop_front());
        end
        ct_head_valid  <= (ct_q.size() != 0);
        tag_head_valid <= (tag_q.size() != 0);
        if (ct_q.size() != 0)
        begin
            ct_head <= ct_q[0];
        end
        if (tag_q.size() != 0)
        begin
            tag_head <= tag_q[0];
        end
        if (cyc >= limit)
        begin
            $display("timeout: no end of test after %0d cycles", limit);
            $display("CHECKS FAILED");
            $fatal(1, "timeout");
        end
    end

    a_reset_quiet: assert property (@(posedge clk)
        in_reset_window |-> (!o_ct.valid && !o_tag.valid))
        else report_failure("output valid high during or right after reset");

    a_ct_when: assert property (@(posedge clk)
        o_ct.valid |-> (ct_head_valid && ct_head.due == cyc))
        else report_failure("o_ct.valid high with no ciphertext block due in this cycle");

    a_ct_missing: assert property (@(posedge clk)
        (ct_head_valid && ct_head.due <= cyc) |-> o_ct.valid)
        else report_failure("expected o_ct.valid did not appear");

    a_ct_value: assert property (@(posedge clk)
        o_ct.valid |-> (o_ct.block == ct_head.value))
        else report_mismatch("o_ct.block", $sampled(ct_head.value), $sampled(o_ct.block));

    a_tag_when: assert property (@(posedge clk)
        o_tag.valid |-> (tag_head_valid && tag_head.due == cyc))
        else report_failure("o_tag.valid high with no tag due in this cycle");

    a_tag_missing: assert property (@(posedge clk)
        (tag_head_valid && tag_head.due <= cyc) |-> o_tag.valid)
        else report_failure("expected o_tag.valid did not appear");

    a_tag_value: assert property (@(posedge clk)
        o_tag.valid |-> (o_tag.tag == tag_head.value))
        else report_mismatch("o_tag.tag", $sampled(tag_head.value), $sampled(o_tag.tag));

    initial
    begin
        int           items;
        logic [127:0] h;
        logic [127:0] ekj0;
        cyc            = '0;
        since_rst      = '0;
        lcg_state      = 32'ha8c7;
        ct_head_valid  = 1'b0;
        tag_head_valid = 1'b0;
        i_new_instance = 1'b0;
        i_h            = '0;
        i_item         = '0;
        // block counts of the random instances are drawn first for the limit
        items = 12;
        for (int k = 0; k < 8; k++)
        begin
            rnd_aad[k]  = (lcg_next() >> 16) % 5;
            rnd_text[k] = (lcg_next() >> 16) % 5;
            items       = items + rnd_aad[k] + rnd_text[k] + 1;
        end
        limit = items + 5 * 12 + 50;
        wait (rst_n === 1'b1);

        // empty instance gives E(K,J0) as its tag
        fill_seq(0, 0);
        h    = rand_block();
        ekj0 = rand_block();
        run_instance(h, ekj0);

        // GCM test case 2 with a zero key and one zero plaintext block
        seq_kind = '{TEXT};
        seq_blk  = '{128'h0388dace60b6a392f328c2b971b2fe78};
        h        = 128'h66e94bd4ef8a2c3b884cfa59ca342b2e;
        ekj0     = 128'h58e2fccefa7e3061367f1d57a4e7455a;
        a_known_answer: assert (model_tag(h, ekj0) == 128'hab6e47d42cec13bdf53a67b21257bddf)
            else report_failure("reference model disagrees with the GCM test vector");
        run_instance(h, ekj0);

        fill_seq(3, 0);
        h    = rand_block();
        ekj0 = rand_block();
        run_instance(h, ekj0);
        fill_seq(0, 4);
        h    = rand_block();
        ekj0 = rand_block();
        run_instance(h, ekj0);

        // back to back with each new-instance pulse right after the final
        for (int k = 0; k < 8; k++)
        begin
            fill_seq(rnd_aad[k], rnd_text[k]);
            h    = rand_block();
            ekj0 = rand_block();
            run_instance(h, ekj0);
        end
        drive_idle();

        while (ct_q.size() != 0 || tag_q.size() != 0)
        begin
            @(posedge clk);
        end
        repeat (3) @(posedge clk);
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule
